/* Bender.yml */
package:
  name: apx_divider

sources:
  - verilog/div_types_pkg.sv
  - verilog/div_ctrl_pkg.sv
  - verilog/apx_adder.sv
  - verilog/div_operand_stage.sv
  - verilog/div_core.sv
  - verilog/div_result_stage.sv
  - verilog/apx_divider_top.sv
  - target: test
    files:
      - test/div_checker.sv
      - test/tb_apx_divider.sv

/* all.f */
verilog/div_types_pkg.sv
verilog/div_ctrl_pkg.sv
verilog/apx_adder.sv
verilog/div_operand_stage.sv
verilog/div_core.sv
verilog/div_result_stage.sv
verilog/apx_divider_top.sv
test/div_checker.sv
test/tb_apx_divider.sv

/* test/div_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module div_checker
(
    input  logic                    CLK,
    input  logic                    rst,
    input  logic                    ready,
    input  logic                    done,
    input  div_types_pkg::operand_t quotient,
    input  div_types_pkg::operand_t remainder
);

    import div_types_pkg::*;

    // Expected results in request order
    operand_t exp_quot[$];
    operand_t exp_rem[$];
    operand_t req_dividend[$];
    operand_t req_divisor[$];
    bit       req_exact[$];             // Also check the division identity

    int checks     = 0;
    int errors     = 0;
    int done_count = 0;

    operand_t    want_q;
    operand_t    want_r;
    operand_t    dvd;
    operand_t    dvs;
    bit          exact;
    logic [63:0] recon;

    task automatic expect_result(input operand_t q, input operand_t r,
                                 input operand_t a, input operand_t b, input bit ex);
        exp_quot.push_back(q);
        exp_rem.push_back(r);
        req_dividend.push_back(a);
        req_divisor.push_back(b);
        req_exact.push_back(ex);
    endtask

    function automatic int outstanding();
        return exp_quot.size();
    endfunction

    task automatic fail_note(input string msg);
        errors++;
        $display("%0d ns: %s", $time, msg);
    endtask

    task automatic compare(input string name, input operand_t got, input operand_t want);
        checks++;
        if (got !== want)
        begin
            errors++;
            $display("** Error at %0d ns: %s = %h, expected %h", $time, name, got, want);
        end
    endtask

    task automatic check_reset_state();
        compare("ready", {31'b0, ready}, 32'd1);
        compare("done", {31'b0, done}, 32'd0);
        compare("quotient", quotient, '0);
        compare("remainder", remainder, '0);
    endtask

    // Sampled mid-cycle away from the clock edge
    always @(negedge CLK)
    begin
        if (!rst && done)
        begin
            done_count++;
            compare("ready", {31'b0, ready}, 32'd1);    // Reopens with done
            if (exp_quot.size() == 0)
                fail_note("done pulsed with no request outstanding");
            else
            begin
                want_q = exp_quot.pop_front();
                want_r = exp_rem.pop_front();
                dvd    = req_dividend.pop_front();
                dvs    = req_divisor.pop_front();
                exact  = req_exact.pop_front();
                compare("quotient", quotient, want_q);
                compare("remainder", remainder, want_r);
                if (exact)
                begin
                    checks++;
                    recon = 64'(quotient) * 64'(dvs) + 64'(remainder);
                    if (recon !== 64'(dvd))
                    begin
                        errors++;
                        $display("** Error at %0d ns: %s = %h, expected %h", $time,
                                 "quotient*divisor+remainder", recon, 64'(dvd));
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

/* test/tb_apx_divider.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_apx_divider;

    import div_types_pkg::*;

    localparam int WAIT_LIMIT = 200;    // Cycles before a wait counts as a hang

    logic     CLK;
    logic     rst;
    logic     start;
    operand_t dividend;
    operand_t divisor;
    err_t     er;
    logic     ready;
    logic     done;
    operand_t quotient;
    operand_t remainder;

    logic [31:0] rng_state = 32'd20548;
    int          err_mark;
    int          done_mark;
    operand_t    a;
    operand_t    b;
    err_t        e;

    apx_divider_top apx_divider_top_inst
    (
        .CLK       (CLK),
        .rst       (rst),
        .start     (start),
        .dividend  (dividend),
        .divisor   (divisor),
        .er        (er),
        .ready     (ready),
        .done      (done),
        .quotient  (quotient),
        .remainder (remainder)
    );

    div_checker result_check
    (
        .CLK       (CLK),
        .rst       (rst),
        .ready     (ready),
        .done      (done),
        .quotient  (quotient),
        .remainder (remainder)
    );

    initial
    begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // Nonzero, spread over all magnitudes
    function automatic operand_t rand_divisor();
        logic [31:0] s;
        operand_t    d;
        s = next_rand() % 32;
        d = next_rand() >> s;
        return (d == '0) ? 32'd1 : d;
    endfunction

    function automatic err_t rand_er();
        logic [31:0] r;
        r = next_rand();
        return r[4] ? r[15:8] : err_t'(r[3:0]);
    endfunction

    // Restoring division, trial subtract with k approximate low bits
    function automatic logic [63:0] model_div(input operand_t dvd, input operand_t dvs,
                                              input err_t er_in);
        int          k;
        operand_t    q;
        operand_t    r;
        logic [32:0] sh;
        logic [32:0] nb;
        logic [32:0] mask;
        logic [32:0] diff;
        logic [33:0] hi;
        logic        c;
        k = (er_in > 8) ? 8 : int'(er_in);
        if (dvs == '0)
            return {32'hFFFF_FFFF, dvd};
        q    = dvd;
        r    = '0;
        nb   = ~{1'b0, dvs};
        mask = (33'd1 << k) - 33'd1;
        for (int step = 0; step < 32; step++)
        begin
            sh   = {r, q[31]};
            c    = (k == 0) ? 1'b1 : (sh[k-1] & nb[k-1]);
            hi   = {1'b0, sh >> k} + {1'b0, nb >> k} + 34'(c);  // Exact upper part
            diff = (hi[32:0] << k) | ((sh | nb) & mask);
            if (hi[33-k])
            begin
                r = diff[31:0];
                q = {q[30:0], 1'b1};
            end
            else
            begin
                r = sh[31:0];
                q = {q[30:0], 1'b0};
            end
        end
        return {q, r};
    endfunction

    task automatic hang(input string what);
        result_check.fail_note({"Timeout, ", what});
        $display("Checks failed");
        $finish;
    endtask

    task automatic wait_ready();
        int n;
        n = 0;
        while (!ready && n < WAIT_LIMIT)
        begin
            @(posedge CLK);
            #1;
            n++;
        end
        if (!ready)
            hang("ready never returned high");
    endtask

    task automatic wait_done();
        int n;
        n = 0;
        while (!done && n < WAIT_LIMIT)
        begin
            @(posedge CLK);
            #1;
            n++;
        end
        if (!done)
            hang("done never pulsed");
    endtask

    task automatic drain();
        int n;
        n = 0;
        while (result_check.outstanding() != 0 && n < WAIT_LIMIT)
        begin
            @(posedge CLK);
            #1;
            n++;
        end
        if (result_check.outstanding() != 0)
            hang("outstanding results never arrived");
    endtask

    task automatic issue(input operand_t dvd, input operand_t dvs, input err_t e_in,
                         input bit exact);
        logic [63:0] pair;
        wait_ready();
        if (exact)
            pair = {dvd / dvs, dvd % dvs};   // True unsigned division
        else
            pair = model_div(dvd, dvs, e_in);
        result_check.expect_result(pair[63:32], pair[31:0], dvd, dvs, exact);
        start    = 1'b1;
        dividend = dvd;
        divisor  = dvs;
        er       = e_in;
        @(posedge CLK);
        #1;
        start = 1'b0;
    endtask

    task automatic report(input int num, input string name, input int count);
        $display("test %0d %s: %0d requests, %0d errors", num, name, count,
                 result_check.errors - err_mark);
        err_mark = result_check.errors;
    endtask

    initial
    begin
        rst      = 1'b1;
        start    = 1'b0;
        dividend = '0;
        divisor  = '0;
        er       = '0;
        err_mark = 0;
        repeat (5) @(posedge CLK);
        #1;
        rst = 1'b0;

        result_check.check_reset_state();
        report(1, "reset state", 0);

        repeat (40)
        begin
            a = next_rand();
            b = rand_divisor();
            issue(a, b, 8'd0, 1'b1);
            wait_done();
        end
        drain();
        report(2, "exact mode", 40);

        // Large settings are replayed with 8, both must match the capped model
        for (int i = 0; i < 60; i++)
        begin
            a = next_rand();
            b = rand_divisor();
            e = rand_er();
            issue(a, b, e, 1'b0);
            wait_done();
            if (e >= 8)
            begin
                issue(a, b, 8'd8, 1'b0);
                wait_done();
            end
        end
        drain();
        report(3, "approximate mode", 60);

        repeat (12)
        begin
            a = next_rand();
            e = err_t'(next_rand());
            issue(a, '0, e, 1'b0);
            wait_done();
        end
        drain();
        report(4, "divide by zero", 12);

        done_mark = result_check.done_count;
        a = next_rand();
        b = rand_divisor();
        issue(a, b, 8'd3, 1'b0);
        repeat (4) @(posedge CLK);
        #1;
        if (ready)
            result_check.fail_note("ready high while a request is in flight");
        start    = 1'b1;        // Must be ignored
        dividend = ~a;
        divisor  = b + 32'd1;
        er       = 8'd0;
        @(posedge CLK);
        #1;
        start = 1'b0;
        wait_done();
        repeat (50) @(posedge CLK);
        #1;
        if (result_check.done_count - done_mark != 1)
            result_check.fail_note("start while busy changed the number of done pulses");
        drain();
        report(5, "start while busy", 1);

        for (int i = 0; i < 20; i++)
        begin
            a = next_rand();
            b = rand_divisor();
            e = rand_er();
            issue(a, b, e, 1'b0);
        end
        drain();
        report(6, "back to back", 20);

        $display("%0d checks, %0d errors, %0d results", result_check.checks,
                 result_check.errors, result_check.done_count);
        if (result_check.errors == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/apx_adder.sv */
`timescale 1ns/1ps
`default_nettype none

module apx_adder
(
    input  div_types_pkg::wide_t     a,
    input  div_types_pkg::wide_t     b,
    input  logic                     cin,
    input  div_types_pkg::apx_bits_t apx_bits,  // Width of the approximate low field
    output div_types_pkg::wide_t     sum,
    output logic                     cout
);

    import div_types_pkg::*;

    logic carry;                                // Running carry through the bit loop

    // Low field is OR only, with no carry chain. The carry leaving it is
    // the AND of the top approximate bit pair, so each approximate bit
    // overwrites it and only the last one survives into the exact part.
    always_comb
    begin
        sum   = '0;
        carry = cin;
        for (int i = 0; i <= DATA_W; i++)
        begin
            if (i < int'(apx_bits))
            begin
                sum[i] = a[i] | b[i];           // Approximate sum bit
                carry  = a[i] & b[i];           // Carry guess from this bit
            end
            else
            begin
                sum[i] = a[i] ^ b[i] ^ carry;   // Exact ripple
                carry  = (a[i] & b[i]) | (carry & (a[i] ^ b[i]));
            end
        end
        cout = carry;
    end

    // The operand stage clips the setting, so a wider field means a broken clip
    apx_bits_cap: assert final ($isunknown(apx_bits) || int'(apx_bits) <= APX_MAX)
        else $error("apx_bits %0d exceeds cap %0d", apx_bits, APX_MAX);

endmodule

`default_nettype wire

/* verilog/apx_divider_top.sv */
`timescale 1ns/1ps
`default_nettype none

module apx_divider_top
(
    input  logic                    CLK,
    input  logic                    rst,
    input  logic                    start,
    input  div_types_pkg::operand_t dividend,
    input  div_types_pkg::operand_t divisor,
    input  div_types_pkg::err_t     er,
    output logic                    ready,
    output logic                    done,
    output div_types_pkg::operand_t quotient,
    output div_types_pkg::operand_t remainder
);

    import div_types_pkg::*;

    logic      go;
    logic      core_busy;
    logic      finish;
    logic      zero_div;
    operand_t  dividend_q;
    operand_t  divisor_q;
    apx_bits_t apx_bits;
    operand_t  quot_raw;
    operand_t  rem_raw;

    div_operand_stage operand_stage
    (
        .CLK        (CLK),
        .rst        (rst),
        .start      (start),
        .dividend   (dividend),
        .divisor    (divisor),
        .er         (er),
        .core_busy  (core_busy),
        .done       (done),
        .ready      (ready),
        .go         (go),
        .dividend_q (dividend_q),
        .divisor_q  (divisor_q),
        .apx_bits   (apx_bits),
        .zero_div   (zero_div)
    );

    div_core core
    (
        .CLK        (CLK),
        .rst        (rst),
        .go         (go),
        .dividend_q (dividend_q),
        .divisor_q  (divisor_q),
        .apx_bits   (apx_bits),
        .core_busy  (core_busy),
        .finish     (finish),
        .quot_raw   (quot_raw),
        .rem_raw    (rem_raw)
    );

    div_result_stage result_stage
    (
        .CLK        (CLK),
        .rst        (rst),
        .finish     (finish),
        .quot_raw   (quot_raw),
        .rem_raw    (rem_raw),
        .zero_div   (zero_div),
        .dividend_q (dividend_q),
        .done       (done),
        .quotient   (quotient),
        .remainder  (remainder)
    );

endmodule

`default_nettype wire

/* verilog/div_core.sv */
`timescale 1ns/1ps
`default_nettype none

module div_core
(
    input  logic                     CLK,
    input  logic                     rst,
    input  logic                     go,
    input  div_types_pkg::operand_t  dividend_q,
    input  div_types_pkg::operand_t  divisor_q,   // Stable until the next go
    input  div_types_pkg::apx_bits_t apx_bits,
    output logic                     core_busy,
    output logic                     finish,
    output div_types_pkg::operand_t  quot_raw,    // Dividend shifts out as quotient shifts in
    output div_types_pkg::operand_t  rem_raw      // Partial remainder
);

    import div_types_pkg::*;
    import div_ctrl_pkg::*;

    core_state_t state;
    count_t      count;

    wide_t shifted;                 // Remainder with next dividend bit appended
    wide_t neg_divisor;
    wide_t diff;
    logic  no_borrow;               // Trial subtraction fits

    assign shifted     = {rem_raw, quot_raw[DATA_W-1]};
    assign neg_divisor = ~{1'b0, divisor_q};

    // Two's complement subtract with the +1 on carry-in
    apx_adder trial_sub
    (
        .a        (shifted),
        .b        (neg_divisor),
        .cin      (1'b1),
        .apx_bits (apx_bits),
        .sum      (diff),
        .cout     (no_borrow)
    );

    assign core_busy = (state != st_idle);
    assign finish    = (state == st_finish);

    always_ff @(posedge CLK)
    begin
        if (rst)
        begin
            state <= st_idle;
            count <= '0;
        end
        else
        begin
            case (state)
                st_idle:
                begin
                    if (go)
                    begin
                        state <= st_run;
                        count <= LAST_STEP;
                    end
                end
                st_run:
                begin
                    if (count == '0)
                        state <= st_finish;       // Step 0 just done
                    count <= count - count_t'(1);
                end
                st_finish:
                begin
                    state <= st_idle;
                end
                default:
                begin
                    state <= st_idle;
                end
            endcase
        end
    end

    always_ff @(posedge CLK)
    begin
        if (state == st_idle && go)
        begin
            quot_raw <= dividend_q;
            rem_raw  <= '0;
        end
        else if (state == st_run)
        begin
            if (no_borrow)
            begin
                rem_raw  <= diff[DATA_W-1:0];
                quot_raw <= {quot_raw[DATA_W-2:0], 1'b1};
            end
            else
            begin
                rem_raw  <= shifted[DATA_W-1:0];   // Restore
                quot_raw <= {quot_raw[DATA_W-2:0], 1'b0};
            end
        end
    end

    // One load cycle plus one step per quotient bit, then a single finish cycle
    finish_one_cycle: assert property (@(posedge CLK) disable iff (rst)
        (state == st_idle) && go |-> ##(int'(LAST_STEP) + 2) finish ##1 !finish)
        else $error("finish missing after the last step or held longer than one cycle");

endmodule

`default_nettype wire

/* verilog/div_ctrl_pkg.sv */
`default_nettype none

package div_ctrl_pkg;

    // Divider core sequencing
    typedef enum logic [1:0] {
        st_idle,                        // Waiting for go
        st_run,                         // One quotient bit per cycle
        st_finish                       // Results valid for one cycle
    } core_state_t;

    // Iteration counter, counts down to zero
    typedef logic [4:0] count_t;

    // First value loaded, one step per quotient bit
    localparam count_t LAST_STEP = 5'd31;

endpackage

`default_nettype wire

/* verilog/div_operand_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module div_operand_stage
(
    input  logic                     CLK,
    input  logic                     rst,
    input  logic                     start,
    input  div_types_pkg::operand_t  dividend,
    input  div_types_pkg::operand_t  divisor,
    input  div_types_pkg::err_t      er,
    input  logic                     core_busy,
    input  logic                     done,        // Result delivered, request retired
    output logic                     ready,
    output logic                     go,
    output div_types_pkg::operand_t  dividend_q,
    output div_types_pkg::operand_t  divisor_q,
    output div_types_pkg::apx_bits_t apx_bits,
    output logic                     zero_div
);

    import div_types_pkg::*;

    logic pending;                                // One request in flight
    logic accept;

    assign ready  = ~pending | done;              // Reopens on the done cycle
    assign accept = start & ready;

    always_ff @(posedge CLK)
    begin
        if (rst)
        begin
            pending  <= 1'b0;
            go       <= 1'b0;
            apx_bits <= '0;
        end
        else
        begin
            go <= accept;                         // Core loads on the next edge
            if (accept)
                pending <= 1'b1;
            else if (done)
                pending <= 1'b0;
            if (accept)
                apx_bits <= (int'(er) > APX_MAX) ? apx_bits_t'(APX_MAX) : apx_bits_t'(er);
        end
    end

    // Held for the whole request
    always_ff @(posedge CLK)
    begin
        if (accept)
        begin
            dividend_q <= dividend;
            divisor_q  <= divisor;
            zero_div   <= (divisor == '0);
        end
    end

    go_while_idle: assert property (@(posedge CLK) disable iff (rst) go |-> !core_busy)
        else $error("go issued while the core is busy");

endmodule

`default_nettype wire

/* verilog/div_result_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module div_result_stage
(
    input  logic                    CLK,
    input  logic                    rst,
    input  logic                    finish,
    input  div_types_pkg::operand_t quot_raw,
    input  div_types_pkg::operand_t rem_raw,
    input  logic                    zero_div,     // From the operand stage
    input  div_types_pkg::operand_t dividend_q,
    output logic                    done,
    output div_types_pkg::operand_t quotient,
    output div_types_pkg::operand_t remainder
);

    always_ff @(posedge CLK)
    begin
        if (rst)
        begin
            done      <= 1'b0;
            quotient  <= '0;
            remainder <= '0;
        end
        else
        begin
            done <= finish;
            if (finish)
            begin
                // Divide by zero ignores the core result
                if (zero_div)
                begin
                    quotient  <= '1;
                    remainder <= dividend_q;
                end
                else
                begin
                    quotient  <= quot_raw;
                    remainder <= rem_raw;
                end
            end
        end
    end

    done_after_finish: assert property (@(posedge CLK) disable iff (rst)
        finish |=> done ##1 !done)
        else $error("done is not a single-cycle pulse one cycle after finish");

endmodule

`default_nettype wire

/* verilog/div_types_pkg.sv */
`default_nettype none

package div_types_pkg;

    // Operand and result width
    localparam int DATA_W = 32;

    // Widest approximate field in the trial subtractor
    localparam int APX_MAX = 8;

    // Dividend, divisor, quotient, remainder
    typedef logic [DATA_W-1:0] operand_t;

    // Shifted partial remainder and trial difference
    typedef logic [DATA_W:0] wide_t;

    // Raw error setting as requested
    typedef logic [7:0] err_t;

    // Effective approximate bit count, 0 to APX_MAX
    typedef logic [3:0] apx_bits_t;

endpackage

`default_nettype wire
